/* source/memory_packet_pkg.sv */
/*
 * Memory response word fields as seen by the configuration loader.
 * The buffer kind encoding must match the one used by the memory front end.
 */
`default_nettype none

package memory_packet_pkg;

    // -------------------------------------------------------------------------
    // Widths
    // -------------------------------------------------------------------------
    localparam int data_w   = 32;
    localparam int offset_w = 32;
    localparam int shift_w  = 5;

    typedef logic [data_w-1:0]   data_t;
    typedef logic [offset_w-1:0] offset_t;
    typedef logic [shift_w-1:0]  shift_t;

    // -------------------------------------------------------------------------
    // Buffer kind carried with every response word
    // -------------------------------------------------------------------------
    // Only the two setup kinds reach the configuration assembler
    typedef enum logic [2:0] {
        buffer_invalid      = 3'd0,
        buffer_cu_setup     = 3'd1,
        buffer_engine_setup = 3'd2,
        buffer_data         = 3'd3
    } buffer_kind_e;

endpackage : memory_packet_pkg

`default_nettype wire

/* source/csr_config_pkg.sv */
/*
 * Engine configuration record and the word layout of one 16-word setup slot.
 * Positions 6, 7 and 11 to 15 count toward completion but carry no field.
 */
`default_nettype none

package csr_config_pkg;

    // -------------------------------------------------------------------------
    // Slot geometry
    // -------------------------------------------------------------------------
    localparam int seq_words   = 16;
    localparam int seq_index_w = 4;

    // One mark per word of the slot
    typedef logic [seq_words-1:0] seq_mark_t;

    // -------------------------------------------------------------------------
    // Configuration field types
    // -------------------------------------------------------------------------
    // Bit 0 increment, bit 1 decrement, bit 2 sequence mode, bit 3 buffer mode
    typedef logic [3:0]  flags_t;
    typedef logic [31:0] index_t;
    typedef logic [63:0] pointer_t;
    typedef logic [30:0] cfg_shift_t;

    // Taken from bits 1:0 of word 5
    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_stream  = 2'd3
    } mem_cmd_e;

    // -------------------------------------------------------------------------
    // Word positions inside the slot
    // -------------------------------------------------------------------------
    localparam int word_flags       = 0;
    localparam int word_index_start = 1;
    localparam int word_index_end   = 2;
    localparam int word_stride      = 3;
    localparam int word_shift       = 4;
    localparam int word_mem_cmd     = 5;
    localparam int word_pointer_lo  = 8;
    localparam int word_pointer_hi  = 9;
    localparam int word_array_size  = 10;

    // -------------------------------------------------------------------------
    // FIFO sizing and record width
    // -------------------------------------------------------------------------
    localparam int fifo_depth       = 16;
    localparam int fifo_prog_thresh = 8;

    // Flags, start, end, stride, shift, direction, command, pointer, size
    localparam int cfg_record_w = $bits(flags_t) + 3 * $bits(index_t)
                                + $bits(cfg_shift_t) + 1 + $bits(mem_cmd_e)
                                + $bits(pointer_t) + $bits(index_t);

endpackage : csr_config_pkg

`default_nettype wire

/* source/fifo_port_if.sv */
/*
 * Push side and pop side of one sync_fifo. No handshake, plain strobes.
 */
`timescale 1ns/1ps
`default_nettype none

interface fifo_port_if #(
    parameter int width = 32
);

    logic             push;
    logic [width-1:0] push_data;
    logic             pop;
    logic [width-1:0] pop_data;
    logic             pop_valid;
    logic             empty;
    logic             prog_full;

    modport writer (
        output push,
        output push_data,
        input  prog_full
    );

    modport reader (
        output pop,
        input  pop_data,
        input  pop_valid,
        input  empty
    );

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output pop_valid,
        output empty,
        output prog_full
    );

endinterface : fifo_port_if

`default_nettype wire

/* source/sync_fifo.sv */
/*
 * Pushes into a full FIFO and pops from an empty one are dropped silently.
 * pop_data and a one-cycle pop_valid follow an accepted pop by one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width       = csr_config_pkg::cfg_record_w,
    parameter int depth       = csr_config_pkg::fifo_depth,
    parameter int prog_thresh = csr_config_pkg::fifo_prog_thresh
) (
    input logic       ap_clk,
    input logic       areset_csr_index_generator,
    fifo_port_if.fifo port
);

    localparam int addr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    logic [width-1:0]   mem [depth];
    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [count_w-1:0] count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    // Wrap explicitly so depths that are not a power of two work
    function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] ptr);
        if (ptr == addr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // -------------------------------------------------------------------------
    // Flags
    // -------------------------------------------------------------------------
    assign port.empty     = (count == '0);
    assign full           = (count == count_w'(depth));
    assign port.prog_full = (count >= count_w'(prog_thresh));

    assign do_push = port.push && !full;
    assign do_pop  = port.pop && !port.empty;

    // -------------------------------------------------------------------------
    // Pointers and fill level
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            port.pop_valid <= 1'b0;
        end else begin
            port.pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Storage and read register
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= port.push_data;
        end
        if (do_pop) begin
            port.pop_data <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

`default_nettype wire

/* source/response_filter.sv */
/*
 * Keeps setup words whose index (offset >> shift) falls in slot engine_slot.
 * No back-pressure to the source. Words pushed into a full FIFO are lost.
 */
`timescale 1ns/1ps
`default_nettype none

module response_filter #(
    parameter int engine_slot = 0
) (
    input logic                           ap_clk,
    input logic                           areset_csr_index_generator,
    input logic                           response_valid,
    input memory_packet_pkg::offset_t     response_offset,
    input memory_packet_pkg::shift_t      response_shift,
    input memory_packet_pkg::buffer_kind_e response_buffer,
    input memory_packet_pkg::data_t       response_data,
    fifo_port_if.writer                   resp_port
);

    localparam int slot_w = memory_packet_pkg::offset_w - csr_config_pkg::seq_index_w;

    logic                           valid_reg;
    memory_packet_pkg::offset_t     offset_reg;
    memory_packet_pkg::shift_t      shift_reg;
    memory_packet_pkg::buffer_kind_e buffer_reg;
    memory_packet_pkg::data_t       data_reg;
    memory_packet_pkg::offset_t     seq_index;
    logic                           setup_kind;
    logic                           in_slot;

    // Input register stage
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        offset_reg <= response_offset;
        shift_reg  <= response_shift;
        buffer_reg <= response_buffer;
        data_reg   <= response_data;
    end

    // -------------------------------------------------------------------------
    // Filter
    // -------------------------------------------------------------------------
    assign seq_index  = offset_reg >> shift_reg;
    assign setup_kind = (buffer_reg == memory_packet_pkg::buffer_cu_setup)
                     || (buffer_reg == memory_packet_pkg::buffer_engine_setup);
    // Upper index bits select the slot
    assign in_slot    = (seq_index[memory_packet_pkg::offset_w-1:csr_config_pkg::seq_index_w]
                         == slot_w'(engine_slot));

    assign resp_port.push      = valid_reg && setup_kind && in_slot;
    assign resp_port.push_data = {seq_index[csr_config_pkg::seq_index_w-1:0], data_reg};

endmodule : response_filter

`default_nettype wire

/* source/csr_config_assembler.sv */
/*
 * A record goes out once all 16 word positions are marked. Fields keep their
 * value across records until rewritten, and a repeated word overwrites.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_config_assembler (
    input logic         ap_clk,
    input logic         areset_csr_index_generator,
    input logic         response_pop,
    fifo_port_if.reader resp_port,
    fifo_port_if.writer cfg_port
);

    logic [csr_config_pkg::seq_index_w-1:0] word_pos;
    memory_packet_pkg::data_t               word_data;
    csr_config_pkg::seq_mark_t              word_bit;
    csr_config_pkg::seq_mark_t              marks;
    logic                                   complete;

    // Decoded fields
    csr_config_pkg::flags_t     flags;
    csr_config_pkg::index_t     index_start;
    csr_config_pkg::index_t     index_end;
    csr_config_pkg::index_t     stride;
    csr_config_pkg::cfg_shift_t shift;
    logic                       shift_left;
    csr_config_pkg::mem_cmd_e   cmd;
    csr_config_pkg::pointer_t   array_pointer;
    csr_config_pkg::index_t     array_size;

    // -------------------------------------------------------------------------
    // Response word split and pop control
    // -------------------------------------------------------------------------
    assign word_pos  = resp_port.pop_data[memory_packet_pkg::data_w +: csr_config_pkg::seq_index_w];
    assign word_data = resp_port.pop_data[memory_packet_pkg::data_w-1:0];
    assign word_bit  = csr_config_pkg::seq_mark_t'(1) << word_pos;
    assign complete  = &marks;

    // Hold off while a record is pending or the output FIFO fills up
    assign resp_port.pop = response_pop && !complete && !cfg_port.prog_full;

    // -------------------------------------------------------------------------
    // Word marks
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            marks <= '0;
        end else if (complete) begin
            // A word popped just before completion starts the next record
            marks <= resp_port.pop_valid ? word_bit : '0;
        end else if (resp_port.pop_valid) begin
            marks <= marks | word_bit;
        end
    end

    // -------------------------------------------------------------------------
    // Field decode
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (resp_port.pop_valid) begin
            case (word_pos)
                csr_config_pkg::word_flags: begin
                    flags <= word_data[3:0];
                end
                csr_config_pkg::word_index_start: begin
                    index_start <= word_data;
                end
                csr_config_pkg::word_index_end: begin
                    index_end <= word_data;
                end
                csr_config_pkg::word_stride: begin
                    stride <= word_data;
                end
                csr_config_pkg::word_shift: begin
                    shift      <= word_data[memory_packet_pkg::data_w-2:0];
                    shift_left <= word_data[memory_packet_pkg::data_w-1];
                end
                csr_config_pkg::word_mem_cmd: begin
                    cmd <= csr_config_pkg::mem_cmd_e'(word_data[1:0]);
                end
                csr_config_pkg::word_pointer_lo: begin
                    array_pointer[31:0] <= word_data;
                end
                csr_config_pkg::word_pointer_hi: begin
                    array_pointer[63:32] <= word_data;
                end
                csr_config_pkg::word_array_size: begin
                    array_size <= word_data;
                end
                default: begin
                    // Positions without a kept field only set their mark
                end
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Record push
    // -------------------------------------------------------------------------
    assign cfg_port.push      = complete;
    assign cfg_port.push_data = {flags, index_start, index_end, stride, shift, shift_left,
                                 cmd, array_pointer, array_size};

endmodule : csr_config_assembler

`default_nettype wire

/* source/csr_index_config_loader.sv */
/*
 * Configuration loader for the engine in slot engine_slot (indices slot*16 on).
 * The source must pace its words, since a full response FIFO drops them.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_index_config_loader #(
    parameter int engine_slot = 0
) (
    input  logic                            ap_clk,
    input  logic                            areset_csr_index_generator,
    input  logic                            response_valid,
    input  memory_packet_pkg::offset_t      response_offset,
    input  memory_packet_pkg::shift_t       response_shift,
    input  memory_packet_pkg::buffer_kind_e response_buffer,
    input  memory_packet_pkg::data_t        response_data,
    input  logic                            response_pop,
    input  logic                            config_pop,
    output logic                            config_valid,
    output csr_config_pkg::flags_t          config_flags,
    output csr_config_pkg::index_t          config_index_start,
    output csr_config_pkg::index_t          config_index_end,
    output csr_config_pkg::index_t          config_stride,
    output csr_config_pkg::cfg_shift_t      config_shift,
    output logic                            config_shift_left,
    output csr_config_pkg::mem_cmd_e        config_cmd,
    output csr_config_pkg::pointer_t        config_array_pointer,
    output csr_config_pkg::index_t          config_array_size
);

    // Sequence index bits followed by the data word
    localparam int resp_w = csr_config_pkg::seq_index_w + memory_packet_pkg::data_w;

    fifo_port_if #(.width(resp_w))                       resp_port ();
    fifo_port_if #(.width(csr_config_pkg::cfg_record_w)) cfg_port ();

    // -------------------------------------------------------------------------
    // Response path
    // -------------------------------------------------------------------------
    response_filter #(
        .engine_slot(engine_slot)
    ) u_response_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_offset           (response_offset),
        .response_shift            (response_shift),
        .response_buffer           (response_buffer),
        .response_data             (response_data),
        .resp_port                 (resp_port.writer)
    );

    sync_fifo #(
        .width      (resp_w),
        .depth      (csr_config_pkg::fifo_depth),
        .prog_thresh(csr_config_pkg::fifo_prog_thresh)
    ) u_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .port                      (resp_port.fifo)
    );

    csr_config_assembler u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_pop              (response_pop),
        .resp_port                 (resp_port.reader),
        .cfg_port                  (cfg_port.writer)
    );

    // -------------------------------------------------------------------------
    // Configuration output
    // -------------------------------------------------------------------------
    sync_fifo #(
        .width      (csr_config_pkg::cfg_record_w),
        .depth      (csr_config_pkg::fifo_depth),
        .prog_thresh(csr_config_pkg::fifo_prog_thresh)
    ) u_cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .port                      (cfg_port.fifo)
    );

    assign cfg_port.pop = config_pop;
    assign config_valid = cfg_port.pop_valid;

    // Same field order as the assembler packs the record
    assign {config_flags, config_index_start, config_index_end, config_stride, config_shift,
            config_shift_left, config_cmd, config_array_pointer,
            config_array_size} = cfg_port.pop_data;

endmodule : csr_index_config_loader

`default_nettype wire

/* verification/tb_csr_index_config_loader.sv */
/*
 * Directed tests of the loader with engine_slot 1, so indices 16 to 31.
 * Words go out two cycles apart, which keeps the response FIFO from overflowing.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_index_config_loader;

    localparam int slot        = 1;
    localparam int slot_base   = slot * 16;
    localparam int num_cfgs    = 7;
    // Several times the summed length of the five tests
    localparam int cycle_limit = 3000;
    localparam int pop_tries   = 100;

    logic                            ap_clk;
    logic                            areset_csr_index_generator;
    logic                            response_valid;
    memory_packet_pkg::offset_t      response_offset;
    memory_packet_pkg::shift_t       response_shift;
    memory_packet_pkg::buffer_kind_e response_buffer;
    memory_packet_pkg::data_t        response_data;
    logic                            response_pop;
    logic                            config_pop;
    logic                            config_valid;
    csr_config_pkg::flags_t          config_flags;
    csr_config_pkg::index_t          config_index_start;
    csr_config_pkg::index_t          config_index_end;
    csr_config_pkg::index_t          config_stride;
    csr_config_pkg::cfg_shift_t      config_shift;
    logic                            config_shift_left;
    csr_config_pkg::mem_cmd_e        config_cmd;
    csr_config_pkg::pointer_t        config_array_pointer;
    csr_config_pkg::index_t          config_array_size;

    memory_packet_pkg::data_t ref_words [num_cfgs][16];
    logic [31:0]              rng_state;
    int                       error_count;
    int                       check_count;

    csr_index_config_loader #(
        .engine_slot(slot)
    ) DUT (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_offset           (response_offset),
        .response_shift            (response_shift),
        .response_buffer           (response_buffer),
        .response_data             (response_data),
        .response_pop              (response_pop),
        .config_pop                (config_pop),
        .config_valid              (config_valid),
        .config_flags              (config_flags),
        .config_index_start        (config_index_start),
        .config_index_end          (config_index_end),
        .config_stride             (config_stride),
        .config_shift              (config_shift),
        .config_shift_left         (config_shift_left),
        .config_cmd                (config_cmd),
        .config_array_pointer      (config_array_pointer),
        .config_array_size         (config_array_size)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // Watchdog
    initial begin
        repeat (cycle_limit) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Reference data and stimulus
    // -------------------------------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_references();
        for (int c = 0; c < num_cfgs; c++) begin
            for (int p = 0; p < 16; p++) begin
                rng_state      = next_random(rng_state);
                ref_words[c][p] = rng_state;
            end
        end
    endtask

    task automatic send_word(input memory_packet_pkg::offset_t offset,
                             input memory_packet_pkg::shift_t shift,
                             input memory_packet_pkg::buffer_kind_e kind,
                             input memory_packet_pkg::data_t data);
        @(posedge ap_clk);
        response_valid  <= 1'b1;
        response_offset <= offset;
        response_shift  <= shift;
        response_buffer <= kind;
        response_data   <= data;
        @(posedge ap_clk);
        response_valid  <= 1'b0;
    endtask

    // Position i*step mod 16 is a permutation for any odd step
    task automatic send_config(input int cfg, input int step,
                               input memory_packet_pkg::shift_t shift);
        int pos;
        memory_packet_pkg::buffer_kind_e kind;
        for (int i = 0; i < 16; i++) begin
            pos  = (i * step) % 16;
            kind = pos[0] ? memory_packet_pkg::buffer_engine_setup
                          : memory_packet_pkg::buffer_cu_setup;
            send_word(memory_packet_pkg::offset_t'((slot_base + pos) << shift), shift, kind,
                      ref_words[cfg][pos]);
        end
    endtask

    // -------------------------------------------------------------------------
    // Compare tasks
    // -------------------------------------------------------------------------
    task automatic check_index(input string name, input csr_config_pkg::index_t got,
                               input csr_config_pkg::index_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pointer(input string name, input csr_config_pkg::pointer_t got,
                                 input csr_config_pkg::pointer_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input csr_config_pkg::flags_t got,
                               input csr_config_pkg::flags_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_shift(input string name, input csr_config_pkg::cfg_shift_t got,
                               input csr_config_pkg::cfg_shift_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input csr_config_pkg::mem_cmd_e got,
                             input csr_config_pkg::mem_cmd_e exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // -------------------------------------------------------------------------
    // Output side
    // -------------------------------------------------------------------------
    // One pop pulse per try and a sample at the falling edge after it
    task automatic pulse_pop();
        @(posedge ap_clk);
        config_pop <= 1'b1;
        @(posedge ap_clk);
        config_pop <= 1'b0;
        @(negedge ap_clk);
    endtask

    task automatic expect_config(input int cfg);
        int tries;
        tries = 0;
        do begin
            pulse_pop();
            tries++;
        end while (config_valid !== 1'b1 && tries < pop_tries);
        check_count++;
        if (config_valid !== 1'b1) begin
            error_count++;
            $display("No configuration record came out for reference set %0d", cfg);
        end else begin
            // Word 0 flags, words 1 to 3 indices, 4 shift, 5 command, 8 to 10 array
            check_flags("config_flags", config_flags, ref_words[cfg][0][3:0]);
            check_index("config_index_start", config_index_start, ref_words[cfg][1]);
            check_index("config_index_end", config_index_end, ref_words[cfg][2]);
            check_index("config_stride", config_stride, ref_words[cfg][3]);
            check_shift("config_shift", config_shift, ref_words[cfg][4][30:0]);
            check_bit("config_shift_left", config_shift_left, ref_words[cfg][4][31]);
            check_cmd("config_cmd", config_cmd,
                      csr_config_pkg::mem_cmd_e'(ref_words[cfg][5][1:0]));
            check_pointer("config_array_pointer", config_array_pointer,
                          {ref_words[cfg][9], ref_words[cfg][8]});
            check_index("config_array_size", config_array_size, ref_words[cfg][10]);
        end
    endtask

    task automatic expect_no_config(input int tries);
        for (int i = 0; i < tries; i++) begin
            pulse_pop();
            check_count++;
            if (config_valid !== 1'b0) begin
                error_count++;
                $display("A configuration record came out where none was expected");
            end
        end
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------
    task automatic test_reset_and_in_order();
        @(posedge ap_clk);
        config_pop <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge ap_clk);
            check_count++;
            if (config_valid !== 1'b0) begin
                error_count++;
                $display("config_valid went high after reset with no input");
            end
        end
        @(posedge ap_clk);
        config_pop <= 1'b0;
        send_config(0, 1, 5'd0);
        expect_config(0);
        expect_no_config(8);
    endtask

    task automatic test_out_of_order();
        // Early stride word that the one inside the permuted set overwrites
        send_word(memory_packet_pkg::offset_t'(slot_base + 3), 5'd0,
                  memory_packet_pkg::buffer_cu_setup, ~ref_words[1][3]);
        send_config(1, 7, 5'd0);
        expect_config(1);
        expect_no_config(8);
    endtask

    task automatic test_filtering();
        memory_packet_pkg::offset_t in_slot;
        for (int p = 0; p < 16; p++) begin
            in_slot = memory_packet_pkg::offset_t'(slot_base + p);
            send_word(in_slot, 5'd0, memory_packet_pkg::buffer_engine_setup, ref_words[2][p]);
            rng_state = next_random(rng_state);
            send_word(in_slot, 5'd0, memory_packet_pkg::buffer_data, rng_state);
            rng_state = next_random(rng_state);
            send_word(in_slot, 5'd0, memory_packet_pkg::buffer_invalid, rng_state);
            // Neighbouring slots 0 and 2
            rng_state = next_random(rng_state);
            send_word(memory_packet_pkg::offset_t'(p), 5'd0,
                      memory_packet_pkg::buffer_engine_setup, rng_state);
            rng_state = next_random(rng_state);
            send_word(memory_packet_pkg::offset_t'(32 + p), 5'd0,
                      memory_packet_pkg::buffer_cu_setup, rng_state);
        end
        expect_config(2);
        expect_no_config(8);
    endtask

    task automatic test_shifted_offsets();
        send_config(3, 1, 5'd2);
        expect_config(3);
        expect_no_config(8);
    endtask

    task automatic test_back_pressure();
        for (int c = 4; c < 7; c++) begin
            send_config(c, 5, 5'd0);
            repeat (10) @(posedge ap_clk);
        end
        for (int c = 4; c < 7; c++) begin
            expect_config(c);
        end
        expect_no_config(8);
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        rng_state   = 32'h6f3a_8d20;
        error_count = 0;
        check_count = 0;
        areset_csr_index_generator <= 1'b1;
        response_valid  <= 1'b0;
        response_offset <= '0;
        response_shift  <= '0;
        response_buffer <= memory_packet_pkg::buffer_invalid;
        response_data   <= '0;
        response_pop    <= 1'b1;
        config_pop      <= 1'b0;
        fill_references();
        repeat (4) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;

        test_reset_and_in_order();
        test_out_of_order();
        test_filtering();
        test_shifted_offsets();
        test_back_pressure();

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_csr_index_config_loader

`default_nettype wire

/* compile.f */
source/memory_packet_pkg.sv
source/csr_config_pkg.sv
source/fifo_port_if.sv
source/sync_fifo.sv
source/response_filter.sv
source/csr_config_assembler.sv
source/csr_index_config_loader.sv
verification/tb_csr_index_config_loader.sv

/* Bender.yml */
package:
  name: csr_index_config_loader

sources:
  - files:
      - source/memory_packet_pkg.sv
      - source/csr_config_pkg.sv
      - source/fifo_port_if.sv
      - source/sync_fifo.sv
      - source/response_filter.sv
      - source/csr_config_assembler.sv
      - source/csr_index_config_loader.sv
  - target: test
    files:
      - verification/tb_csr_index_config_loader.sv
